/* logic/fabric_pkg.sv */
package fabric_pkg;

    // Bus geometry
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int SEL_W       = DATA_W / 8;
    localparam int SRAM_ADDR_W = 20;  // Word address into one 4 MiB chip

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [SEL_W-1:0]       sel_t;
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    // Address map
    localparam addr_t BASE_RAM_BASE = 32'h8000_0000;
    localparam addr_t EXT_RAM_BASE  = 32'h8040_0000;
    localparam addr_t RAM_MASK      = 32'hFFC0_0000;  // 4 MiB windows

    // SRAM timing in sys_clk cycles with the strobes held low
    localparam int SRAM_ACCESS_CYCLES = 2;

    // Access counter sized to hold the last access cycle index
    localparam int SRAM_CNT_W = $clog2(SRAM_ACCESS_CYCLES + 1);
    localparam logic [SRAM_CNT_W-1:0] SRAM_LAST_CNT = SRAM_CNT_W'(SRAM_ACCESS_CYCLES - 1);

endpackage

/* logic/bus_arbiter.sv */
module bus_arbiter (
    input  logic              sys_clk,
    input  logic              sys_rst,

    // Instruction port, read only
    input  logic              inst_cyc_i,
    input  logic              inst_stb_i,
    input  fabric_pkg::addr_t inst_adr_i,
    output fabric_pkg::data_t inst_dat_o,
    output logic              inst_ack_o,
    output logic              inst_err_o,

    // Data port
    input  logic              data_cyc_i,
    input  logic              data_stb_i,
    input  logic              data_we_i,
    input  fabric_pkg::sel_t  data_sel_i,
    input  fabric_pkg::addr_t data_adr_i,
    input  fabric_pkg::data_t data_dat_i,
    output fabric_pkg::data_t data_dat_o,
    output logic              data_ack_o,
    output logic              data_err_o,

    // Shared master side towards the decoder
    output logic              m_cyc_o,
    output logic              m_stb_o,
    output logic              m_we_o,
    output fabric_pkg::sel_t  m_sel_o,
    output fabric_pkg::addr_t m_adr_o,
    output fabric_pkg::data_t m_dat_o,
    input  fabric_pkg::data_t m_dat_i,
    input  logic              m_ack_i,
    input  logic              m_err_i
);

    logic data_req;
    logic inst_req;
    logic gnt_busy;     // Bus owned for the current cycle
    logic gnt_is_data;  // Owner when busy
    logic gnt_data;
    logic gnt_inst;

    assign data_req = data_cyc_i & data_stb_i;
    assign inst_req = inst_cyc_i & inst_stb_i;
    assign gnt_data = gnt_busy & gnt_is_data;
    assign gnt_inst = gnt_busy & ~gnt_is_data;

    // Grant is locked until the owner sees ack or err
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            gnt_busy    <= 1'b0;
            gnt_is_data <= 1'b0;
        end else if (!gnt_busy) begin
            if (data_req || inst_req) begin
                gnt_busy    <= 1'b1;
                gnt_is_data <= data_req;  // Data port wins ties
            end
        end else if (m_ack_i || m_err_i) begin
            gnt_busy <= 1'b0;
        end
    end

    always_comb begin
        m_cyc_o = 1'b0;
        m_stb_o = 1'b0;
        m_we_o  = 1'b0;
        m_sel_o = '1;
        m_adr_o = inst_adr_i;
        m_dat_o = data_dat_i;
        if (gnt_data) begin
            m_cyc_o = data_cyc_i;
            m_stb_o = data_stb_i;
            m_we_o  = data_we_i;
            m_sel_o = data_sel_i;
            m_adr_o = data_adr_i;
        end else if (gnt_inst) begin
            m_cyc_o = inst_cyc_i;
            m_stb_o = inst_stb_i;  // Full word fetch, never a write
        end
    end

    // Responses go to the owner only
    assign data_dat_o = gnt_data ? m_dat_i : '0;
    assign data_ack_o = gnt_data & m_ack_i;
    assign data_err_o = gnt_data & m_err_i;
    assign inst_dat_o = gnt_inst ? m_dat_i : '0;
    assign inst_ack_o = gnt_inst & m_ack_i;
    assign inst_err_o = gnt_inst & m_err_i;

endmodule

/* logic/addr_decoder.sv */
module addr_decoder (
    input  logic                   sys_clk,
    input  logic                   sys_rst,

    // Master side from the arbiter
    input  logic                   m_cyc_i,
    input  logic                   m_stb_i,
    input  logic                   m_we_i,
    input  fabric_pkg::sel_t       m_sel_i,
    input  fabric_pkg::addr_t      m_adr_i,
    input  fabric_pkg::data_t      m_dat_i,
    output fabric_pkg::data_t      m_dat_o,
    output logic                   m_ack_o,
    output logic                   m_err_o,

    // Slave 0, base RAM
    output logic                   s0_cyc_o,
    output logic                   s0_stb_o,
    output logic                   s0_we_o,
    output fabric_pkg::sel_t       s0_sel_o,
    output fabric_pkg::sram_addr_t s0_adr_o,
    output fabric_pkg::data_t      s0_dat_o,
    input  fabric_pkg::data_t      s0_dat_i,
    input  logic                   s0_ack_i,

    // Slave 1, ext RAM
    output logic                   s1_cyc_o,
    output logic                   s1_stb_o,
    output logic                   s1_we_o,
    output fabric_pkg::sel_t       s1_sel_o,
    output fabric_pkg::sram_addr_t s1_adr_o,
    output fabric_pkg::data_t      s1_dat_o,
    input  fabric_pkg::data_t      s1_dat_i,
    input  logic                   s1_ack_i
);

    logic                   hit_base;
    logic                   hit_ext;
    logic                   err_q;
    fabric_pkg::sram_addr_t word_adr;

    assign hit_base = (m_adr_i & fabric_pkg::RAM_MASK) == fabric_pkg::BASE_RAM_BASE;
    assign hit_ext  = (m_adr_i & fabric_pkg::RAM_MASK) == fabric_pkg::EXT_RAM_BASE;
    assign word_adr = m_adr_i[fabric_pkg::SRAM_ADDR_W+1:2];  // Drop byte offset

    // Only the selected slave sees the strobe
    assign s0_cyc_o = m_cyc_i & hit_base;
    assign s0_stb_o = m_stb_i & hit_base;
    assign s0_we_o  = m_we_i;
    assign s0_sel_o = m_sel_i;
    assign s0_adr_o = word_adr;
    assign s0_dat_o = m_dat_i;

    assign s1_cyc_o = m_cyc_i & hit_ext;
    assign s1_stb_o = m_stb_i & hit_ext;
    assign s1_we_o  = m_we_i;
    assign s1_sel_o = m_sel_i;
    assign s1_adr_o = word_adr;
    assign s1_dat_o = m_dat_i;

    assign m_dat_o = hit_ext ? s1_dat_i : s0_dat_i;
    assign m_ack_o = (hit_base & s0_ack_i) | (hit_ext & s1_ack_i);
    assign m_err_o = err_q;

    // Unmapped access gets a single err pulse
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_cyc_i && m_stb_i && !hit_base && !hit_ext && !err_q;
        end
    end

endmodule

/* logic/sram_controller.sv */
module sram_controller (
    input  logic                   sys_clk,
    input  logic                   sys_rst,

    // Bus slave side
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  fabric_pkg::sel_t       sel_i,
    input  fabric_pkg::sram_addr_t adr_i,
    input  fabric_pkg::data_t      dat_i,
    output fabric_pkg::data_t      dat_o,
    output logic                   ack_o,

    // Asynchronous SRAM pins
    output fabric_pkg::sram_addr_t sram_addr_o,
    input  fabric_pkg::data_t      sram_data_i,
    output fabric_pkg::data_t      sram_data_o,
    output logic                   sram_data_oe_o,
    output logic                   sram_ce_n_o,
    output logic                   sram_oe_n_o,
    output logic                   sram_we_n_o,
    output fabric_pkg::sel_t       sram_be_n_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE,
        ST_WAIT
    } state_t;

    state_t                            state;
    logic [fabric_pkg::SRAM_CNT_W-1:0] acc_cnt;
    logic                              start;
    logic                              last_cycle;

    assign start      = (state == ST_IDLE) && cyc_i && stb_i;
    assign last_cycle = (state == ST_ACCESS) && (acc_cnt == fabric_pkg::SRAM_LAST_CNT);

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state       <= ST_IDLE;
            acc_cnt     <= '0;
            sram_ce_n_o <= 1'b1;
            sram_oe_n_o <= 1'b1;
            sram_we_n_o <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state       <= ST_ACCESS;
                        acc_cnt     <= '0;
                        sram_ce_n_o <= 1'b0;
                        sram_oe_n_o <= we_i;   // Read drives oe_n
                        sram_we_n_o <= !we_i;  // Write drives we_n
                    end
                end
                ST_ACCESS: begin
                    if (last_cycle) begin
                        state       <= ST_DONE;
                        sram_ce_n_o <= 1'b1;
                        sram_oe_n_o <= 1'b1;
                        sram_we_n_o <= 1'b1;
                    end else begin
                        acc_cnt <= acc_cnt + 1'b1;
                    end
                end
                ST_DONE: state <= ST_WAIT;  // Ack cycle
                ST_WAIT: begin
                    // Hold off until the master drops stb
                    if (!stb_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Latched request payload
    always_ff @(posedge sys_clk) begin
        if (start) begin
            sram_addr_o <= adr_i;
            sram_be_n_o <= ~sel_i;
            sram_data_o <= dat_i;
        end
    end

    // Read data sampled as the access ends
    always_ff @(posedge sys_clk) begin
        if (last_cycle && !sram_oe_n_o) begin
            dat_o <= sram_data_i;
        end
    end

    assign ack_o          = (state == ST_DONE);
    assign sram_data_oe_o = !sram_we_n_o;  // Drive the pins only during a write

endmodule

/* logic/mem_fabric_top.sv */
module mem_fabric_top (
    input  logic                   sys_clk,
    input  logic                   sys_rst,

    // Instruction port
    input  logic                   inst_cyc_i,
    input  logic                   inst_stb_i,
    input  fabric_pkg::addr_t      inst_adr_i,
    output fabric_pkg::data_t      inst_dat_o,
    output logic                   inst_ack_o,
    output logic                   inst_err_o,

    // Data port
    input  logic                   data_cyc_i,
    input  logic                   data_stb_i,
    input  logic                   data_we_i,
    input  fabric_pkg::sel_t       data_sel_i,
    input  fabric_pkg::addr_t      data_adr_i,
    input  fabric_pkg::data_t      data_dat_i,
    output fabric_pkg::data_t      data_dat_o,
    output logic                   data_ack_o,
    output logic                   data_err_o,

    // Base RAM pins
    output fabric_pkg::sram_addr_t base_ram_addr_o,
    input  fabric_pkg::data_t      base_ram_data_i,
    output fabric_pkg::data_t      base_ram_data_o,
    output logic                   base_ram_data_oe_o,
    output logic                   base_ram_ce_n_o,
    output logic                   base_ram_oe_n_o,
    output logic                   base_ram_we_n_o,
    output fabric_pkg::sel_t       base_ram_be_n_o,

    // Ext RAM pins
    output fabric_pkg::sram_addr_t ext_ram_addr_o,
    input  fabric_pkg::data_t      ext_ram_data_i,
    output fabric_pkg::data_t      ext_ram_data_o,
    output logic                   ext_ram_data_oe_o,
    output logic                   ext_ram_ce_n_o,
    output logic                   ext_ram_oe_n_o,
    output logic                   ext_ram_we_n_o,
    output fabric_pkg::sel_t       ext_ram_be_n_o
);

    // Arbiter to decoder
    logic                   m_cyc, m_stb, m_we, m_ack, m_err;
    fabric_pkg::sel_t       m_sel;
    fabric_pkg::addr_t      m_adr;
    fabric_pkg::data_t      m_wdat, m_rdat;

    // Decoder to controllers
    logic                   s0_cyc, s0_stb, s0_we, s0_ack;
    logic                   s1_cyc, s1_stb, s1_we, s1_ack;
    fabric_pkg::sel_t       s0_sel, s1_sel;
    fabric_pkg::sram_addr_t s0_adr, s1_adr;
    fabric_pkg::data_t      s0_wdat, s0_rdat, s1_wdat, s1_rdat;

    bus_arbiter i_arbiter (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .inst_cyc_i (inst_cyc_i),
        .inst_stb_i (inst_stb_i),
        .inst_adr_i (inst_adr_i),
        .inst_dat_o (inst_dat_o),
        .inst_ack_o (inst_ack_o),
        .inst_err_o (inst_err_o),
        .data_cyc_i (data_cyc_i),
        .data_stb_i (data_stb_i),
        .data_we_i  (data_we_i),
        .data_sel_i (data_sel_i),
        .data_adr_i (data_adr_i),
        .data_dat_i (data_dat_i),
        .data_dat_o (data_dat_o),
        .data_ack_o (data_ack_o),
        .data_err_o (data_err_o),
        .m_cyc_o    (m_cyc),
        .m_stb_o    (m_stb),
        .m_we_o     (m_we),
        .m_sel_o    (m_sel),
        .m_adr_o    (m_adr),
        .m_dat_o    (m_wdat),
        .m_dat_i    (m_rdat),
        .m_ack_i    (m_ack),
        .m_err_i    (m_err)
    );

    addr_decoder i_decoder (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .m_cyc_i  (m_cyc),
        .m_stb_i  (m_stb),
        .m_we_i   (m_we),
        .m_sel_i  (m_sel),
        .m_adr_i  (m_adr),
        .m_dat_i  (m_wdat),
        .m_dat_o  (m_rdat),
        .m_ack_o  (m_ack),
        .m_err_o  (m_err),
        .s0_cyc_o (s0_cyc),
        .s0_stb_o (s0_stb),
        .s0_we_o  (s0_we),
        .s0_sel_o (s0_sel),
        .s0_adr_o (s0_adr),
        .s0_dat_o (s0_wdat),
        .s0_dat_i (s0_rdat),
        .s0_ack_i (s0_ack),
        .s1_cyc_o (s1_cyc),
        .s1_stb_o (s1_stb),
        .s1_we_o  (s1_we),
        .s1_sel_o (s1_sel),
        .s1_adr_o (s1_adr),
        .s1_dat_o (s1_wdat),
        .s1_dat_i (s1_rdat),
        .s1_ack_i (s1_ack)
    );

    // Base window at 0x8000_0000
    sram_controller i_base_ctrl (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .cyc_i          (s0_cyc),
        .stb_i          (s0_stb),
        .we_i           (s0_we),
        .sel_i          (s0_sel),
        .adr_i          (s0_adr),
        .dat_i          (s0_wdat),
        .dat_o          (s0_rdat),
        .ack_o          (s0_ack),
        .sram_addr_o    (base_ram_addr_o),
        .sram_data_i    (base_ram_data_i),
        .sram_data_o    (base_ram_data_o),
        .sram_data_oe_o (base_ram_data_oe_o),
        .sram_ce_n_o    (base_ram_ce_n_o),
        .sram_oe_n_o    (base_ram_oe_n_o),
        .sram_we_n_o    (base_ram_we_n_o),
        .sram_be_n_o    (base_ram_be_n_o)
    );

    // Ext window at 0x8040_0000
    sram_controller i_ext_ctrl (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .cyc_i          (s1_cyc),
        .stb_i          (s1_stb),
        .we_i           (s1_we),
        .sel_i          (s1_sel),
        .adr_i          (s1_adr),
        .dat_i          (s1_wdat),
        .dat_o          (s1_rdat),
        .ack_o          (s1_ack),
        .sram_addr_o    (ext_ram_addr_o),
        .sram_data_i    (ext_ram_data_i),
        .sram_data_o    (ext_ram_data_o),
        .sram_data_oe_o (ext_ram_data_oe_o),
        .sram_ce_n_o    (ext_ram_ce_n_o),
        .sram_oe_n_o    (ext_ram_oe_n_o),
        .sram_we_n_o    (ext_ram_we_n_o),
        .sram_be_n_o    (ext_ram_be_n_o)
    );

endmodule

/* testbench/sram_model.sv */
module sram_model #(
    parameter fabric_pkg::data_t FILL_KEY = 32'h0
) (
    input  fabric_pkg::sram_addr_t addr_i,
    input  fabric_pkg::data_t      data_i,   // Write data from the controller
    output fabric_pkg::data_t      data_o,   // Read data to the controller
    input  logic                   ce_n_i,
    input  logic                   oe_n_i,
    input  logic                   we_n_i,
    input  fabric_pkg::sel_t       be_n_i
);

    timeunit 1ns;
    timeprecision 1ps;

    fabric_pkg::data_t mem [0:(1 << fabric_pkg::SRAM_ADDR_W)-1];

    // Fill pattern built from every address bit
    initial begin
        fabric_pkg::sram_addr_t w;
        for (int i = 0; i < (1 << fabric_pkg::SRAM_ADDR_W); i++) begin
            w = fabric_pkg::sram_addr_t'(i);
            mem[i] = {~w[11:0], w} ^ FILL_KEY;
        end
    end

    assign data_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : '0;

    // Write lands shortly after we_n falls, once address and data settle
    always @(negedge we_n_i) begin
        #1;
        if (!ce_n_i && !we_n_i) begin
            for (int b = 0; b < fabric_pkg::SEL_W; b++) begin
                if (!be_n_i[b]) mem[addr_i][8*b +: 8] = data_i[8*b +: 8];
            end
        end
    end

endmodule

/* testbench/sram_controller_props.sv */
module sram_controller_props (
    input logic sys_clk,
    input logic sys_rst,
    input logic stb_i,
    input logic ack_o,
    input logic sram_ce_n_o,
    input logic sram_oe_n_o,
    input logic sram_we_n_o,
    input logic sram_data_oe_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Never read and write the chip at once
    a_no_oe_we: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(!sram_oe_n_o && !sram_we_n_o))
        else $error("oe_n and we_n low together");

    a_ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
        ack_o |=> !ack_o)
        else $error("ack held longer than one cycle");

    // Write data only goes out to a selected chip
    a_drive_on_write: assert property (@(posedge sys_clk) disable iff (sys_rst)
        sram_data_oe_o |-> !sram_ce_n_o)
        else $error("data pins driven with the chip deselected");

    // No request, no strobes
    a_idle_strobes: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !stb_i |-> (sram_ce_n_o && sram_oe_n_o && sram_we_n_o))
        else $error("SRAM strobe low without a request");

endmodule

bind sram_controller sram_controller_props i_props (
    .sys_clk        (sys_clk),
    .sys_rst        (sys_rst),
    .stb_i          (stb_i),
    .ack_o          (ack_o),
    .sram_ce_n_o    (sram_ce_n_o),
    .sram_oe_n_o    (sram_oe_n_o),
    .sram_we_n_o    (sram_we_n_o),
    .sram_data_oe_o (sram_data_oe_o)
);

/* testbench/tb_mem_fabric.sv */
module tb_mem_fabric;

    timeunit 1ns;
    timeprecision 1ps;

    localparam fabric_pkg::data_t KEY_BASE = 32'h1111_0000;
    localparam fabric_pkg::data_t KEY_EXT  = 32'h2222_0000;
    localparam int N_WORD = 40;   // write, read, read other window
    localparam int N_BYTE = 30;   // write, read
    localparam int N_INST = 20;
    localparam int N_UNMAP = 10;  // per port
    localparam int N_CONC = 30;   // two ops each
    localparam int TOTAL_OPS = 3*N_WORD + 2*N_BYTE + N_INST + 2*N_UNMAP + 2*N_CONC + 4;
    localparam int CYCLE_LIMIT = 40 * TOTAL_OPS;

    logic sys_clk, sys_rst;
    logic inst_cyc, inst_stb, inst_ack, inst_err;
    logic data_cyc, data_stb, data_we, data_ack, data_err;
    fabric_pkg::addr_t inst_adr, data_adr;
    fabric_pkg::data_t inst_rdat, data_wdat, data_rdat;
    fabric_pkg::sel_t  data_sel;

    fabric_pkg::sram_addr_t base_addr, ext_addr;
    fabric_pkg::data_t base_din, base_dout, ext_din, ext_dout;
    logic base_oe, base_ce_n, base_oe_n, base_we_n;
    logic ext_oe, ext_ce_n, ext_oe_n, ext_we_n;
    fabric_pkg::sel_t base_be_n, ext_be_n;

    fabric_pkg::data_t shadow [fabric_pkg::addr_t];
    fabric_pkg::addr_t written [$];
    int errors, tests_run, tests_failed, cycles, ce_falls;

    mem_fabric_top i_dut (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .inst_cyc_i(inst_cyc), .inst_stb_i(inst_stb), .inst_adr_i(inst_adr),
        .inst_dat_o(inst_rdat), .inst_ack_o(inst_ack), .inst_err_o(inst_err),
        .data_cyc_i(data_cyc), .data_stb_i(data_stb), .data_we_i(data_we),
        .data_sel_i(data_sel), .data_adr_i(data_adr), .data_dat_i(data_wdat),
        .data_dat_o(data_rdat), .data_ack_o(data_ack), .data_err_o(data_err),
        .base_ram_addr_o(base_addr), .base_ram_data_i(base_dout),
        .base_ram_data_o(base_din), .base_ram_data_oe_o(base_oe),
        .base_ram_ce_n_o(base_ce_n), .base_ram_oe_n_o(base_oe_n),
        .base_ram_we_n_o(base_we_n), .base_ram_be_n_o(base_be_n),
        .ext_ram_addr_o(ext_addr), .ext_ram_data_i(ext_dout),
        .ext_ram_data_o(ext_din), .ext_ram_data_oe_o(ext_oe),
        .ext_ram_ce_n_o(ext_ce_n), .ext_ram_oe_n_o(ext_oe_n),
        .ext_ram_we_n_o(ext_we_n), .ext_ram_be_n_o(ext_be_n)
    );

    sram_model #(.FILL_KEY(KEY_BASE)) i_base_ram (
        .addr_i(base_addr), .data_i(base_din), .data_o(base_dout),
        .ce_n_i(base_ce_n), .oe_n_i(base_oe_n), .we_n_i(base_we_n), .be_n_i(base_be_n)
    );

    sram_model #(.FILL_KEY(KEY_EXT)) i_ext_ram (
        .addr_i(ext_addr), .data_i(ext_din), .data_o(ext_dout),
        .ce_n_i(ext_ce_n), .oe_n_i(ext_oe_n), .we_n_i(ext_we_n), .be_n_i(ext_be_n)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(negedge base_ce_n or negedge ext_ce_n) ce_falls++;

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a bus cycle never completed", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Power-up content of each chip, keyed by window
    function automatic fabric_pkg::data_t fill_word(input fabric_pkg::addr_t a);
        fabric_pkg::sram_addr_t w;
        fabric_pkg::data_t key;
        w = a[21:2];
        key = ((a & fabric_pkg::RAM_MASK) == fabric_pkg::EXT_RAM_BASE) ? KEY_EXT : KEY_BASE;
        return {~w[11:0], w} ^ key;
    endfunction

    function automatic fabric_pkg::data_t model_read(input fabric_pkg::addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return fill_word(a);
    endfunction

    function automatic void model_write(input fabric_pkg::addr_t a, input fabric_pkg::sel_t sel,
                                        input fabric_pkg::data_t d);
        fabric_pkg::data_t w;
        w = model_read(a);
        for (int b = 0; b < fabric_pkg::SEL_W; b++) begin
            if (sel[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        shadow[a] = w;
    endfunction

    function automatic fabric_pkg::addr_t rand_window_addr(input logic ext);
        fabric_pkg::addr_t a;
        a = ext ? fabric_pkg::EXT_RAM_BASE : fabric_pkg::BASE_RAM_BASE;
        a[21:2] = fabric_pkg::sram_addr_t'($urandom);
        return a;
    endfunction

    function automatic fabric_pkg::addr_t rand_unmapped_addr();
        fabric_pkg::addr_t a;
        do begin
            a = $urandom;
        end while (((a & fabric_pkg::RAM_MASK) == fabric_pkg::BASE_RAM_BASE) ||
                   ((a & fabric_pkg::RAM_MASK) == fabric_pkg::EXT_RAM_BASE));
        return {a[31:2], 2'b00};
    endfunction

    task automatic check_data(input string name, input fabric_pkg::data_t exp,
                              input fabric_pkg::data_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic data_access(input logic we, input fabric_pkg::sel_t sel,
                               input fabric_pkg::addr_t adr, input fabric_pkg::data_t wdat,
                               output fabric_pkg::data_t rdat, output logic ack,
                               output logic err);
        @(negedge sys_clk);
        data_cyc = 1'b1;
        data_stb = 1'b1;
        data_we = we;
        data_sel = sel;
        data_adr = adr;
        data_wdat = wdat;
        do @(negedge sys_clk); while (!(data_ack || data_err));
        rdat = data_rdat;
        ack = data_ack;
        err = data_err;
        @(negedge sys_clk);
        if (data_ack || data_err) begin
            $display("Data port saw a second response at %h", adr);
            errors++;
        end
        data_cyc = 1'b0;  // Dropped in the cycle after the response
        data_stb = 1'b0;
        data_we = 1'b0;
    endtask

    task automatic inst_access(input fabric_pkg::addr_t adr, output fabric_pkg::data_t rdat,
                               output logic ack, output logic err);
        @(negedge sys_clk);
        inst_cyc = 1'b1;
        inst_stb = 1'b1;
        inst_adr = adr;
        do @(negedge sys_clk); while (!(inst_ack || inst_err));
        rdat = inst_rdat;
        ack = inst_ack;
        err = inst_err;
        @(negedge sys_clk);
        if (inst_ack || inst_err) begin
            $display("Instruction port saw a second response at %h", adr);
            errors++;
        end
        inst_cyc = 1'b0;
        inst_stb = 1'b0;
    endtask

    initial begin
        fabric_pkg::addr_t a, b;
        fabric_pkg::data_t d, rd, ird;
        fabric_pkg::sel_t s;
        logic ack, err, iack, ierr, ext, we;
        int e0, falls0;

        void'($urandom(32'h7cce));
        {inst_cyc, inst_stb, data_cyc, data_stb, data_we} = '0;
        inst_adr = '0;
        data_adr = '0;
        data_sel = '0;
        data_wdat = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        ce_falls = 0;
        sys_rst = 1'b1;
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;

        e0 = errors;
        repeat (4) begin
            @(negedge sys_clk);
            check_err("reset_idle base ce_n", 1'b1, base_ce_n);
            check_err("reset_idle base oe_n", 1'b1, base_oe_n);
            check_err("reset_idle base we_n", 1'b1, base_we_n);
            check_err("reset_idle base data_oe", 1'b0, base_oe);
            check_err("reset_idle ext ce_n", 1'b1, ext_ce_n);
            check_err("reset_idle ext oe_n", 1'b1, ext_oe_n);
            check_err("reset_idle ext we_n", 1'b1, ext_we_n);
            check_err("reset_idle ext data_oe", 1'b0, ext_oe);
            check_err("reset_idle responses", 1'b0,
                      inst_ack | inst_err | data_ack | data_err);
        end
        report_test("reset_idle", e0);

        e0 = errors;
        for (int i = 0; i < N_WORD; i++) begin
            ext = 1'($urandom);
            a = rand_window_addr(ext);
            b = a ^ (fabric_pkg::BASE_RAM_BASE ^ fabric_pkg::EXT_RAM_BASE);  // Same word
            d = $urandom;
            data_access(1'b1, '1, a, d, rd, ack, err);
            model_write(a, '1, d);
            written.push_back(a);
            check_err("word_rw write ack", 1'b1, ack);
            data_access(1'b0, '1, a, '0, rd, ack, err);
            check_data("word_rw read", model_read(a), rd);
            data_access(1'b0, '1, b, '0, rd, ack, err);
            check_data("word_rw other window", model_read(b), rd);
        end
        report_test("word_rw", e0);

        e0 = errors;
        for (int i = 0; i < N_BYTE; i++) begin
            a = rand_window_addr(1'($urandom));
            s = fabric_pkg::sel_t'($urandom);
            d = $urandom;
            data_access(1'b1, s, a, d, rd, ack, err);
            model_write(a, s, d);
            written.push_back(a);
            data_access(1'b0, '1, a, '0, rd, ack, err);
            check_data("byte_sel read", model_read(a), rd);
        end
        report_test("byte_sel", e0);

        e0 = errors;
        for (int i = 0; i < N_INST; i++) begin
            a = written[$urandom % written.size()];
            inst_access(a, ird, iack, ierr);
            check_err("inst_read ack", 1'b1, iack);
            check_data("inst_read", model_read(a), ird);
        end
        report_test("inst_read", e0);

        e0 = errors;
        falls0 = ce_falls;
        for (int i = 0; i < N_UNMAP; i++) begin
            data_access(1'($urandom), '1, rand_unmapped_addr(), $urandom, rd, ack, err);
            check_err("unmapped data err", 1'b1, err);
            check_err("unmapped data ack", 1'b0, ack);
            inst_access(rand_unmapped_addr(), ird, iack, ierr);
            check_err("unmapped inst err", 1'b1, ierr);
            check_err("unmapped inst ack", 1'b0, iack);
        end
        if (ce_falls != falls0) begin
            $display("An SRAM chip enable fell during unmapped accesses");
            errors++;
        end
        report_test("unmapped", e0);

        // Data port in the base window, instruction fetch in the ext window
        e0 = errors;
        for (int i = 0; i < N_CONC; i++) begin
            a = rand_window_addr(1'b0);
            b = rand_window_addr(1'b1);
            we = 1'($urandom);
            d = $urandom;
            fork
                data_access(we, '1, a, d, rd, ack, err);
                inst_access(b, ird, iack, ierr);
            join
            check_err("concurrent data ack", 1'b1, ack);
            check_err("concurrent inst ack", 1'b1, iack);
            check_data("concurrent inst read", model_read(b), ird);
            if (we) begin
                model_write(a, '1, d);
            end else begin
                check_data("concurrent data read", model_read(a), rd);
            end
        end
        report_test("concurrent", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* project.f */
logic/fabric_pkg.sv
logic/bus_arbiter.sv
logic/addr_decoder.sv
logic/sram_controller.sv
logic/mem_fabric_top.sv
testbench/sram_model.sv
testbench/sram_controller_props.sv
testbench/tb_mem_fabric.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory fabric simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mem_fabric -f project.f -o sim_mem_fabric \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_mem_fabric > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation ended without a pass result"; exit 1; }
